// ==== source/env_step_cfg.svh ====
`ifndef ENV_STEP_CFG_SVH
`define ENV_STEP_CFG_SVH

// sizes
`define ENV_NUM      8       // environments per run
`define DATA_WL      32      // memory word width
`define ADDR_WL      16      // byte address width
`define WEA_WL       4       // byte write enables
`define ACT_WL       2       // bits per action
`define STEP_LATENCY 2       // pe pipeline depth

// physics
`define POS_LIMIT    1000    // done when |pos| exceeds this

// word address map of the shared memory
`define STATE_BASE   0       // first env state
`define ACT_ADDR     8       // packed actions, 2 bits per env
`define FLAG_ADDR    9       // start flag, cleared at end of run
`define OBS_BASE     10      // first observation
`define RWD_ADDR     18      // packed reward bits
`define DONE_ADDR    19      // packed done bits

`endif

// ==== source/cart_pkg.sv ====
`include "env_step_cfg.svh"

package cart_pkg;

    // one env state/observation word, either raw or split into halves
    typedef union packed {
        logic [`DATA_WL-1:0] raw;          // as stored in memory
        struct packed {
            logic signed [15:0] pos;       // upper half
            logic signed [15:0] vel;       // lower half
        } st;
    } cart_word_u;

    // action field of the packed action word
    typedef enum logic [`ACT_WL-1:0] {
        ACT_LEFT      = 2'd0,              // vel - 1
        ACT_RIGHT     = 2'd1,              // vel + 1
        ACT_COAST     = 2'd2,
        ACT_COAST_ALT = 2'd3               // treated as coast too
    } action_e;

endpackage

// ==== source/bus_pkg.sv ====
`include "env_step_cfg.svh"

package bus_pkg;

    typedef logic [`DATA_WL-1:0] word_t;        // memory data word
    typedef logic [`ADDR_WL-3:0] word_addr_t;   // byte address without the 2 lsbs

    // sequencer phase
    typedef enum logic [2:0] {
        PH_IDLE    = 3'd0,   // polling the start flag
        PH_READ    = 3'd1,   // fetching actions and states
        PH_COMPUTE = 3'd2,   // issuing steps, draining the pe
        PH_WRITE   = 3'd3,   // obs, reward, done write back
        PH_CLEAR   = 3'd4    // zero the start flag
    } phase_e;

endpackage

// ==== source/step_if.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

interface step_if;

    // request side, sequencer to pe
    logic                        req_valid;
    logic [$clog2(`ENV_NUM)-1:0] req_idx;
    cart_pkg::cart_word_u        req_state;
    cart_pkg::action_e           req_action;

    // result side, pe to writer; valid qualifies data in the same cycle
    logic                        res_valid;
    logic [$clog2(`ENV_NUM)-1:0] res_idx;
    cart_pkg::cart_word_u        res_obs;
    logic                        res_rwd;
    logic                        res_done;

    modport seq    (output req_valid, req_idx, req_state, req_action);
    modport pe     (input  req_valid, req_idx, req_state, req_action,
                    output res_valid, res_idx, res_obs, res_rwd, res_done);
    modport writer (input  res_valid, res_idx, res_obs, res_rwd, res_done);

endinterface

// ==== source/cart_step_pe.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

module cart_step_pe (
    input  logic i_clk,
    input  logic i_rstn,
    step_if.pe   step
);

    logic                        s1_valid;
    logic [$clog2(`ENV_NUM)-1:0] s1_idx;
    cart_pkg::cart_word_u        s1_word;   // pos unchanged, vel already updated
    cart_pkg::cart_word_u        s1_nxt;
    cart_pkg::cart_word_u        obs_nxt;
    logic                        done_nxt;

    // stage 1, action on velocity
    always_comb begin
        s1_nxt = step.req_state;
        case (step.req_action)
            cart_pkg::ACT_LEFT:  s1_nxt.st.vel = step.req_state.st.vel - 16'sd1;
            cart_pkg::ACT_RIGHT: s1_nxt.st.vel = step.req_state.st.vel + 16'sd1;
            default:             s1_nxt.st.vel = step.req_state.st.vel;  // coast
        endcase
    end

    // stage 2, integrate position and check the track limit
    always_comb begin
        obs_nxt        = s1_word;
        obs_nxt.st.pos = s1_word.st.pos + s1_word.st.vel;   // wraps at 16 bits
        done_nxt       = (obs_nxt.st.pos > `POS_LIMIT) || (obs_nxt.st.pos < -(`POS_LIMIT));
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            s1_valid       <= 1'b0;
            step.res_valid <= 1'b0;
        end else begin
            s1_valid       <= step.req_valid;
            step.res_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_idx        <= step.req_idx;
        s1_word       <= s1_nxt;
        step.res_idx  <= s1_idx;        // index rides with the item
        step.res_obs  <= obs_nxt;
        step.res_done <= done_nxt;
        step.res_rwd  <= !done_nxt;
    end

endmodule

// ==== source/result_writer.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

module result_writer (
    input  logic                          i_clk,
    input  logic                          i_rstn,
    step_if.writer                        step,
    input  logic [$clog2(`ENV_NUM+3)-1:0] i_wr_slot,
    output bus_pkg::word_t                o_data
);

    localparam int IDX_WL  = $clog2(`ENV_NUM);
    localparam int SLOT_WL = $clog2(`ENV_NUM + 3);

    cart_pkg::cart_word_u obs_buf [`ENV_NUM];  // observation per env
    logic [`ENV_NUM-1:0]  rwd_bits;
    logic [`ENV_NUM-1:0]  done_bits;

    always_ff @(posedge i_clk) begin
        if (step.res_valid) begin
            obs_buf[step.res_idx] <= step.res_obs;
        end
    end

    // packed bits, env 0 starts a fresh run
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            rwd_bits  <= '0;
            done_bits <= '0;
        end else if (step.res_valid) begin
            if (step.res_idx == '0) begin
                rwd_bits  <= {{(`ENV_NUM-1){1'b0}}, step.res_rwd};
                done_bits <= {{(`ENV_NUM-1){1'b0}}, step.res_done};
            end else begin
                rwd_bits[step.res_idx]  <= step.res_rwd;
                done_bits[step.res_idx] <= step.res_done;
            end
        end
    end

    // word for the slot being written
    always_comb begin
        if (i_wr_slot < SLOT_WL'(`ENV_NUM)) begin
            o_data = obs_buf[IDX_WL'(i_wr_slot)].raw;
        end else if (i_wr_slot == SLOT_WL'(`ENV_NUM)) begin
            o_data = {{(`DATA_WL-`ENV_NUM){1'b0}}, rwd_bits};
        end else if (i_wr_slot == SLOT_WL'(`ENV_NUM + 1)) begin
            o_data = {{(`DATA_WL-`ENV_NUM){1'b0}}, done_bits};
        end else begin
            o_data = '0;    // flag clear
        end
    end

endmodule

// ==== source/env_sequencer.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

module env_sequencer (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    input  bus_pkg::word_t                      i_data,
    output bus_pkg::word_addr_t                 o_word_addr,
    output logic [`WEA_WL-1:0]                  o_wea,
    output logic [$clog2(`ENV_NUM+3)-1:0]       o_wr_slot,
    step_if.seq                                 step
);

    localparam int IDX_WL  = $clog2(`ENV_NUM);
    localparam int SLOT_WL = $clog2(`ENV_NUM + 3);
    localparam int CNT_WL  = $clog2(`ENV_NUM + `STEP_LATENCY + 3);

    bus_pkg::phase_e      phase, phase_nxt;
    logic                 idle_q;      // previous cycle was idle, i_data is a clean flag read
    logic [CNT_WL-1:0]    cnt;         // position inside the current phase
    logic [CNT_WL-1:0]    cnt_q;       // cnt one cycle late, lines up with i_data
    logic                 rd_vld_q;    // i_data holds a read phase word
    logic [IDX_WL-1:0]    cap_idx;
    logic [IDX_WL-1:0]    req_idx;
    bus_pkg::word_t       act_word;    // packed actions of this run
    cart_pkg::cart_word_u state_reg [`ENV_NUM];

    always_comb begin
        phase_nxt = phase;
        case (phase)
            bus_pkg::PH_IDLE: begin
                if (idle_q && (i_data != '0)) begin
                    phase_nxt = bus_pkg::PH_READ;
                end
            end
            bus_pkg::PH_READ: begin
                if (cnt == CNT_WL'(`ENV_NUM)) begin   // action + ENV_NUM states presented
                    phase_nxt = bus_pkg::PH_COMPUTE;
                end
            end
            bus_pkg::PH_COMPUTE: begin
                if (cnt == CNT_WL'(`ENV_NUM + `STEP_LATENCY - 1)) begin // last result due
                    phase_nxt = bus_pkg::PH_WRITE;
                end
            end
            bus_pkg::PH_WRITE: begin
                if (cnt == CNT_WL'(`ENV_NUM + 1)) begin
                    phase_nxt = bus_pkg::PH_CLEAR;
                end
            end
            default: phase_nxt = bus_pkg::PH_IDLE;  // clear lasts one cycle
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            phase    <= bus_pkg::PH_IDLE;
            idle_q   <= 1'b0;
            cnt      <= '0;
            cnt_q    <= '0;
            rd_vld_q <= 1'b0;
        end else begin
            phase    <= phase_nxt;
            idle_q   <= (phase == bus_pkg::PH_IDLE);
            cnt_q    <= cnt;
            rd_vld_q <= (phase == bus_pkg::PH_READ);
            if (phase_nxt != phase) begin
                cnt <= '0;
            end else if (phase != bus_pkg::PH_IDLE) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // action word comes first, then state i at read slot i+1
    assign cap_idx = IDX_WL'(cnt_q - 1'b1);

    always_ff @(posedge i_clk) begin
        if (rd_vld_q) begin
            if (cnt_q == '0) begin
                act_word <= i_data;
            end else begin
                state_reg[cap_idx] <= i_data;
            end
        end
    end

    // one request per cycle in the first ENV_NUM compute cycles
    assign req_idx         = IDX_WL'(cnt);
    assign step.req_valid  = (phase == bus_pkg::PH_COMPUTE) && (cnt < CNT_WL'(`ENV_NUM));
    assign step.req_idx    = req_idx;
    assign step.req_state  = state_reg[req_idx];
    assign step.req_action = cart_pkg::action_e'(act_word[`ACT_WL*req_idx +: `ACT_WL]);

    always_comb begin
        case (phase)
            bus_pkg::PH_READ: begin
                if (cnt == '0) begin
                    o_word_addr = bus_pkg::word_addr_t'(`ACT_ADDR);
                end else begin
                    o_word_addr = bus_pkg::word_addr_t'(`STATE_BASE + cnt - 1);
                end
            end
            bus_pkg::PH_WRITE: begin
                if (cnt < CNT_WL'(`ENV_NUM)) begin
                    o_word_addr = bus_pkg::word_addr_t'(`OBS_BASE + cnt);
                end else if (cnt == CNT_WL'(`ENV_NUM)) begin
                    o_word_addr = bus_pkg::word_addr_t'(`RWD_ADDR);
                end else begin
                    o_word_addr = bus_pkg::word_addr_t'(`DONE_ADDR);
                end
            end
            default: o_word_addr = bus_pkg::word_addr_t'(`FLAG_ADDR); // idle poll, clear write
        endcase
    end

    assign o_wea     = ((phase == bus_pkg::PH_WRITE) || (phase == bus_pkg::PH_CLEAR)) ? '1 : '0;
    assign o_wr_slot = (phase == bus_pkg::PH_WRITE) ? SLOT_WL'(cnt)
                                                    : SLOT_WL'(`ENV_NUM + 2); // clear slot

endmodule

// ==== source/env_step_top.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

module env_step_top (
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic [`DATA_WL-1:0] i_data,
    output logic [`DATA_WL-1:0] o_data,
    output logic [`ADDR_WL-1:0] o_addr,
    output logic [`WEA_WL-1:0]  o_wea
);

    bus_pkg::word_addr_t                word_addr;
    logic [$clog2(`ENV_NUM+3)-1:0]      wr_slot;

    step_if step_bus ();

    env_sequencer i_sequencer (
        .i_clk       ( i_clk     ),
        .i_rstn      ( i_rstn    ),
        .i_data      ( i_data    ),
        .o_word_addr ( word_addr ),
        .o_wea       ( o_wea     ),
        .o_wr_slot   ( wr_slot   ),
        .step        ( step_bus  )
    );

    cart_step_pe i_pe (
        .i_clk  ( i_clk    ),
        .i_rstn ( i_rstn   ),
        .step   ( step_bus )
    );

    result_writer i_writer (
        .i_clk     ( i_clk    ),
        .i_rstn    ( i_rstn   ),
        .step      ( step_bus ),
        .i_wr_slot ( wr_slot  ),
        .o_data    ( o_data   )
    );

    assign o_addr = {word_addr, 2'b00};   // word to byte address

endmodule

// ==== tb/tb_env_step.sv ====
`timescale 1ns/100ps
`include "env_step_cfg.svh"

module tb_env_step;

    localparam int RUNS   = 7;                  // one directed run, six random ones
    localparam int QUIET  = 20;                 // idle cycles before the first start
    localparam int WR_RUN = `ENV_NUM + 3;       // obs, reward, done, flag clear
    localparam int LIMIT  = RUNS * 60 + QUIET + 200;

    logic                i_clk;
    logic                i_rstn;
    logic [`DATA_WL-1:0] i_data = '0;
    logic [`DATA_WL-1:0] o_data;
    logic [`ADDR_WL-1:0] o_addr;
    logic [`WEA_WL-1:0]  o_wea;

    bus_pkg::word_t      mem [32];
    bus_pkg::word_t      stage [`FLAG_ADDR + 1];   // host image of the next run
    logic [`ADDR_WL-1:0] exp_addr [WR_RUN];
    bus_pkg::word_t      exp_data [WR_RUN];
    int                  errors       = 0;
    int                  checks       = 0;
    int                  wr_cnt       = 0;
    int                  runs_started = 0;
    int                  runs_done    = 0;
    int                  runs_loaded  = 0;
    int                  cycles       = 0;
    bus_pkg::phase_e     stuck_phase;

    env_step_top i_dut (
        .i_clk  ( i_clk  ),
        .i_rstn ( i_rstn ),
        .i_data ( i_data ),
        .o_data ( o_data ),
        .o_addr ( o_addr ),
        .o_wea  ( o_wea  )
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // next obs word, reward and done for one env
    function automatic logic [`DATA_WL+1:0] step_ref(input cart_pkg::cart_word_u s,
                                                     input cart_pkg::action_e a);
        logic signed [15:0] pos;
        logic signed [15:0] vel;
        logic               done;
        pos = s.st.pos;
        vel = s.st.vel;
        if (a == cart_pkg::ACT_LEFT) begin
            vel = vel - 16'sd1;
        end else if (a == cart_pkg::ACT_RIGHT) begin
            vel = vel + 16'sd1;
        end
        pos  = pos + vel;                       // wraps at 16 bits
        done = (int'(pos) > `POS_LIMIT) || (int'(pos) < -`POS_LIMIT);
        return {pos, vel, !done, done};
    endfunction

    task automatic prepare_run(input int run);
        cart_pkg::cart_word_u st;
        cart_pkg::action_e    act;
        bus_pkg::word_t       acts;
        bus_pkg::word_t       rwd_word;
        bus_pkg::word_t       done_word;
        logic [`DATA_WL+1:0]  res;
        acts      = (run == 0) ? 32'h0000_e4e4 : $urandom();  // directed: env i gets i%4
        rwd_word  = '0;
        done_word = '0;
        for (int i = 0; i < `ENV_NUM; i++) begin
            if (run == 0) begin
                st.st.pos = (i < 4) ? 16'sd1000 : -16'sd1000;   // right at the limit
                st.st.vel = (i == 3) ? 16'sd1 : (i == 6) ? -16'sd1 : 16'sd0;
            end else if (run % 2 == 1) begin
                st.raw = $urandom();            // full range, hits the wrap
            end else begin
                st.st.pos = 16'(int'($urandom_range(2400)) - 1200);
                st.st.vel = 16'(int'($urandom_range(20)) - 10);
            end
            act          = cart_pkg::action_e'(acts[`ACT_WL*i +: `ACT_WL]);
            res          = step_ref(st, act);
            stage[`STATE_BASE + i] = st.raw;
            exp_addr[i]  = `ADDR_WL'((`OBS_BASE + i) * 4);
            exp_data[i]  = res[`DATA_WL+1:2];
            rwd_word[i]  = res[1];
            done_word[i] = res[0];
        end
        stage[`ACT_ADDR]           = acts;
        stage[`FLAG_ADDR]          = bus_pkg::word_t'(run + 1);
        exp_addr[`ENV_NUM]         = `ADDR_WL'(`RWD_ADDR * 4);
        exp_data[`ENV_NUM]         = rwd_word;
        exp_addr[`ENV_NUM + 1]     = `ADDR_WL'(`DONE_ADDR * 4);
        exp_data[`ENV_NUM + 1]     = done_word;
        exp_addr[`ENV_NUM + 2]     = `ADDR_WL'(`FLAG_ADDR * 4);
        exp_data[`ENV_NUM + 2]     = '0;
    endtask

    // shared memory, one cycle read latency
    always @(posedge i_clk) begin
        if (!i_rstn) begin
            for (int a = 0; a < 32; a++) begin
                mem[a] <= {16'hface, 16'(a)};
            end
            mem[`FLAG_ADDR] <= '0;
            runs_loaded     <= 0;
        end else if (runs_loaded != runs_started) begin
            for (int a = 0; a <= `FLAG_ADDR; a++) begin
                mem[a] <= stage[a];             // host drops in a new batch
            end
            runs_loaded <= runs_started;
        end else if (o_wea != '0) begin
            mem[o_addr[6:2]] <= o_data;
        end
        i_data <= mem[o_addr[6:2]];
    end

    // write checker
    always @(negedge i_clk) begin
        if (i_rstn && runs_started == 0) begin
            assert (o_wea == '0 && o_addr == `ADDR_WL'(`FLAG_ADDR * 4)) else begin
                errors++;
                $display("** Error at %0t: bus not idle, addr %h wea %h", $time, o_addr, o_wea);
            end
        end
        if (o_wea != '0) begin
            assert (runs_done < runs_started) else begin
                errors++;
                $display("the DUT wrote to address %h while no run was started", o_addr);
            end
            if (runs_done < runs_started) begin
                checks++;
                assert (o_wea == '1 && o_addr == exp_addr[wr_cnt] && o_data == exp_data[wr_cnt])
                else begin
                    errors++;
                    $display("** Error at %0t: run %0d write %0d got addr %h data %h wea %h,",
                             $time, runs_done, wr_cnt, o_addr, o_data, o_wea);
                    $display("   expected addr %h data %h", exp_addr[wr_cnt], exp_data[wr_cnt]);
                end
                if (wr_cnt == WR_RUN - 1) begin
                    wr_cnt = 0;
                    runs_done++;                // flag clear ends the run
                end else begin
                    wr_cnt++;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            stuck_phase = i_dut.i_sequencer.phase;
            $display("timeout after %0d cycles with %0d of %0d runs done, sequencer in %s",
                     cycles, runs_done, RUNS, stuck_phase.name());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h674d));
        i_rstn = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rstn <= 1'b1;
        repeat (QUIET) @(negedge i_clk);        // flag still zero, bus must stay idle
        for (int r = 0; r < RUNS; r++) begin
            @(negedge i_clk);
            prepare_run(r);
            runs_started = r + 1;
            wait (runs_done == r + 1);
        end
        repeat (10) @(negedge i_clk);           // any stray write shows up here
        $display("runs: %0d, writes checked: %0d, errors: %0d", runs_done, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/cart_pkg.sv
source/bus_pkg.sv
source/step_if.sv
source/cart_step_pe.sv
source/result_writer.sv
source/env_sequencer.sv
source/env_step_top.sv
tb/tb_env_step.sv

// ==== Makefile ====
# Verilator build for the env step engine testbench

VERILATOR  ?= verilator
TOP        ?= tb_env_step
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
